/* src/soc_addr_pkg.sv */
// boot memory address map, address types and physical address union
package soc_addr_pkg;

   localparam int PADDR_WIDTH     = 32;
   localparam int BRAM_ADDR_WIDTH = 16;    // 64 KB window
   localparam int LINE_OFFSET     = 3;     // 8 bytes per line
   localparam int LINE_IDX_WIDTH  = BRAM_ADDR_WIDTH - LINE_OFFSET;
   localparam int BRAM_LINES      = 2 ** LINE_IDX_WIDTH;

   typedef logic [PADDR_WIDTH-1:0]    paddr_t;
   typedef logic [LINE_IDX_WIDTH-1:0] line_idx_t;

   // crossbar style window rule, hit when (addr & ~mask) == base
   localparam paddr_t BRAM_BASE = 32'h0000_0000;
   localparam paddr_t BRAM_MASK = 32'h0000_ffff;

   typedef struct packed {
      logic [PADDR_WIDTH-BRAM_ADDR_WIDTH-1:0] tag;    // window select bits
      line_idx_t                              line;
      logic [LINE_OFFSET-1:0]                 offset; // byte within line
   } paddr_fields_t;

   // same address word, flat or split into window fields
   typedef union packed {
      paddr_t        raw;
      paddr_fields_t fields;
   } paddr_u;

endpackage

/* src/soc_bus_pkg.sv */
// single-word bus request, response, stage structs and response codes
package soc_bus_pkg;

   localparam int DATA_WIDTH = 64;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [STRB_WIDTH-1:0] strb_t;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_DECERR = 2'b11     // nothing mapped at this address
   } resp_e;

   typedef struct packed {
      soc_addr_pkg::paddr_t addr;
      logic                 we;
      data_t                wdata;
      strb_t                wstrb;
   } mem_req_t;

   typedef struct packed {
      data_t rdata;
      resp_e resp;
   } mem_rsp_t;

   // decode to bram stage
   typedef struct packed {
      logic                    valid;
      logic                    hit;
      soc_addr_pkg::line_idx_t line;
      logic                    we;
      data_t                   wdata;
      strb_t                   wstrb;
   } dec_req_t;

   // bram to response stage
   typedef struct packed {
      logic  valid;
      logic  hit;
      logic  we;
      data_t rdata;
   } exe_rsp_t;

endpackage

/* src/mem_addr_decode.sv */
// request capture from the req/ack handshake and BRAM window decode
`timescale 1ns/1ps

module mem_addr_decode (
   input  logic                  mig_clk,
   input  logic                  rst_n_i,
   input  logic                  req_i,
   input  soc_bus_pkg::mem_req_t mem_req_i,
   output soc_bus_pkg::dec_req_t dec_o
);
   import soc_addr_pkg::*;
   import soc_bus_pkg::*;

   typedef enum logic {
      IDLE,
      WAIT_LOW
   } state_e;

   state_e    state_q;
   logic      accept;
   paddr_u    addr_u;
   logic      hit;
   logic      dec_vld_q;
   logic      hit_q;
   line_idx_t line_q;
   logic      we_q;
   data_t     wdata_q;
   strb_t     wstrb_q;

   assign accept = (state_q == IDLE) && req_i; // one capture per req phase

   always_comb begin
      addr_u.raw = mem_req_i.addr;
      hit        = (addr_u.raw & ~BRAM_MASK) == BRAM_BASE;
   end

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= IDLE;
         dec_vld_q <= 1'b0;
      end else begin
         dec_vld_q <= accept;  // single cycle pulse
         if (accept) begin
            state_q <= WAIT_LOW;
         end else if (!req_i) begin
            state_q <= IDLE;
         end
      end
   end

   always_ff @(posedge mig_clk) begin
      if (accept) begin
         hit_q   <= hit;
         line_q  <= addr_u.fields.line;
         we_q    <= mem_req_i.we;
         wdata_q <= mem_req_i.wdata;
         wstrb_q <= mem_req_i.wstrb;
      end
   end

   always_comb begin
      dec_o.valid = dec_vld_q;
      dec_o.hit   = hit_q;
      dec_o.line  = line_q;
      dec_o.we    = we_q;
      dec_o.wdata = wdata_q;
      dec_o.wstrb = wstrb_q;
   end

endmodule

/* src/bram_access.sv */
// inferred boot BRAM with byte strobed write and registered read address
`timescale 1ns/1ps

module bram_access (
   input  logic                  mig_clk,
   input  logic                  rst_n_i,
   input  soc_bus_pkg::dec_req_t dec_i,
   output soc_bus_pkg::exe_rsp_t exe_o
);
   import soc_addr_pkg::*;
   import soc_bus_pkg::*;

   data_t     mem [BRAM_LINES];
   line_idx_t rd_line_q;
   logic      wr_en;
   logic      rd_en;
   logic      exe_vld_q;
   logic      hit_q;
   logic      we_q;

   // misses never touch the array
   assign wr_en = dec_i.valid && dec_i.hit && dec_i.we;
   assign rd_en = dec_i.valid && dec_i.hit && !dec_i.we;

   always_ff @(posedge mig_clk) begin
      if (wr_en) begin
         for (int i = 0; i < STRB_WIDTH; i++) begin
            if (dec_i.wstrb[i]) begin
               mem[dec_i.line][i*8 +: 8] <= dec_i.wdata[i*8 +: 8];
            end
         end
      end
      if (rd_en) begin
         rd_line_q <= dec_i.line;   // read port address register
      end
   end

   always_ff @(posedge mig_clk) begin
      if (dec_i.valid) begin
         hit_q <= dec_i.hit;
         we_q  <= dec_i.we;
      end
   end

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exe_vld_q <= 1'b0;
      end else begin
         exe_vld_q <= dec_i.valid;
      end
   end

   always_comb begin
      exe_o.valid = exe_vld_q;
      exe_o.hit   = hit_q;
      exe_o.we    = we_q;
      exe_o.rdata = mem[rd_line_q];  // data follows the address register
   end

endmodule

/* src/resp_collect.sv */
// response coding and the ack side of the four-phase handshake
`timescale 1ns/1ps

module resp_collect (
   input  logic                  mig_clk,
   input  logic                  rst_n_i,
   input  logic                  req_i,
   input  soc_bus_pkg::exe_rsp_t exe_i,
   output logic                  ack_o,
   output soc_bus_pkg::mem_rsp_t mem_rsp_o
);
   import soc_bus_pkg::*;

   mem_rsp_t rsp_d;

   // only hit reads carry data back
   always_comb begin
      rsp_d.resp  = exe_i.hit ? RESP_OKAY : RESP_DECERR;
      rsp_d.rdata = (exe_i.hit && !exe_i.we) ? exe_i.rdata : '0;
   end

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o     <= 1'b0;
         mem_rsp_o <= '0;
      end else begin
         if (exe_i.valid) begin
            ack_o     <= 1'b1;
            mem_rsp_o <= rsp_d;
         end else if (!req_i) begin
            ack_o <= 1'b0;      // requester has released
         end
      end
   end

endmodule

/* src/boot_mem_top.sv */
// boot memory top with decode, BRAM and response stages
`timescale 1ns/1ps

module boot_mem_top (
   input  logic                  mig_clk,
   input  logic                  rst_n_i,
   input  logic                  req_i,
   input  soc_bus_pkg::mem_req_t mem_req_i,
   output logic                  ack_o,
   output soc_bus_pkg::mem_rsp_t mem_rsp_o
);
   import soc_bus_pkg::*;

   dec_req_t dec;
   exe_rsp_t exe;

   // request capture and window check
   mem_addr_decode u_decode (
      .mig_clk   ( mig_clk   ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( req_i     ),
      .mem_req_i ( mem_req_i ),
      .dec_o     ( dec       )
   );

   bram_access u_bram (
      .mig_clk ( mig_clk ),
      .rst_n_i ( rst_n_i ),
      .dec_i   ( dec     ),
      .exe_o   ( exe     )
   );

   // ack follows two stages behind capture
   resp_collect u_resp (
      .mig_clk   ( mig_clk   ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( req_i     ),
      .exe_i     ( exe       ),
      .ack_o     ( ack_o     ),
      .mem_rsp_o ( mem_rsp_o )
   );

endmodule

/* verification/tb_clk_gen.sv */
// free running 4 ns testbench clock
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o
);
   initial begin
      clk_o = 1'b0;
   end

   always #2 clk_o = ~clk_o;   // 250 MHz

endmodule

/* verification/boot_mem_checker.sv */
// four-phase handshake assertions bound to the boot memory top
`timescale 1ns/1ps

module boot_mem_checker (
   input logic                  mig_clk,
   input logic                  rst_n_i,
   input logic                  req_i,
   input logic                  ack_i,
   input soc_bus_pkg::mem_rsp_t mem_rsp_i
);

   int fail_count = 0;   // assertion failures so far

   // ack only answers a request already seen high
   ack_needs_req: assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      $rose(ack_i) |-> $past(req_i))
      else begin
         fail_count++;
         $error("ack rose while req was low");
      end

   ack_held: assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      ack_i && req_i |=> ack_i)
      else begin
         fail_count++;
         $error("ack dropped while req still high");
      end

   rsp_stable: assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      ack_i |=> !ack_i || $stable(mem_rsp_i))
      else begin
         fail_count++;
         $error("response changed while ack high");
      end

   ack_low_in_reset: assert property (@(posedge mig_clk)
      !rst_n_i |-> !ack_i)
      else begin
         fail_count++;
         $error("ack high during reset");
      end

endmodule

/* verification/boot_mem_tb.sv */
// boot memory testbench with random stimulus, reference model and report
`timescale 1ns/1ps

module boot_mem_tb;
   import soc_addr_pkg::*;
   import soc_bus_pkg::*;

   localparam int         TIMEOUT     = 50;
   localparam int         POOL_SIZE   = 16;
   localparam logic [1:0] OKAY_CODE   = 2'b00;
   localparam logic [1:0] DECERR_CODE = 2'b11;

   logic     mig_clk;
   logic     rst_n_i;
   logic     req_i;
   mem_req_t mem_req_i;
   logic     ack_o;
   mem_rsp_t mem_rsp_o;

   data_t    model [int];   // expected line contents
   int       pool_line [POOL_SIZE];
   string    cur_test;
   int       errors;
   int       checks;
   int       tests;
   int       failed_tests;
   int       test_start_errors;

   tb_clk_gen u_clk_gen (
      .clk_o ( mig_clk )
   );

   boot_mem_top dut (
      .mig_clk   ( mig_clk   ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( req_i     ),
      .mem_req_i ( mem_req_i ),
      .ack_o     ( ack_o     ),
      .mem_rsp_o ( mem_rsp_o )
   );

   bind boot_mem_top boot_mem_checker u_checker (
      .mig_clk   ( mig_clk   ),
      .rst_n_i   ( rst_n_i   ),
      .req_i     ( req_i     ),
      .ack_i     ( ack_o     ),
      .mem_rsp_i ( mem_rsp_o )
   );

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("CHECK FAILED %s (%s) expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("ERROR in %s: no response, timed out waiting for %s", cur_test, what);
      $display("TEST FAILED");
      $finish;
   endtask

   function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
      data_t res;
      res = old;
      for (int b = 0; b < STRB_WIDTH; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return res;
   endfunction

   function automatic data_t rand_word();
      return {$urandom, $urandom};
   endfunction

   function automatic paddr_t pool_addr(input int idx);
      return {16'h0000, 13'(pool_line[idx]), 3'($urandom)};
   endfunction

   // window bits nonzero, low bits alias a pool line
   function automatic paddr_t miss_addr(input int idx);
      return {16'($urandom_range(16'hffff, 1)), 13'(pool_line[idx]), 3'($urandom)};
   endfunction

   // one four-phase transfer, latencies counted in rising edges
   task automatic access(input mem_req_t r, input int hold, output mem_rsp_t rsp,
                         output int rise_lat, output int fall_lat);
      @(posedge mig_clk);
      mem_req_i <= r;
      req_i     <= 1'b1;
      rise_lat = 0;
      do begin
         @(posedge mig_clk);
         @(negedge mig_clk);
         rise_lat++;
      end while (!ack_o && rise_lat < TIMEOUT);
      if (!ack_o) begin
         abort_on_timeout("ack_o to rise");
      end
      rsp = mem_rsp_o;
      for (int i = 0; i < hold; i++) begin
         @(negedge mig_clk);
         check_val("held ack", 1, ack_o);
         check_val("held rdata", rsp.rdata, mem_rsp_o.rdata);
         check_val("held resp", 64'(rsp.resp), 64'(mem_rsp_o.resp));
      end
      @(posedge mig_clk);
      req_i <= 1'b0;
      fall_lat = 0;
      do begin
         @(posedge mig_clk);
         @(negedge mig_clk);
         fall_lat++;
      end while (ack_o && fall_lat < TIMEOUT);
      if (ack_o) begin
         abort_on_timeout("ack_o to fall");
      end
   endtask

   task automatic checked_access(input logic we, input paddr_t addr, input data_t wdata,
                                 input strb_t strb, input int hold);
      mem_req_t   r;
      mem_rsp_t   rsp;
      int         rise_lat;
      int         fall_lat;
      logic       hit;
      int         line;
      data_t      exp_data;
      logic [1:0] exp_resp;
      r.addr   = addr;
      r.we     = we;
      r.wdata  = wdata;
      r.wstrb  = strb;
      hit      = (addr[31:16] == 16'h0000);
      line     = int'(addr[15:3]);
      exp_resp = hit ? OKAY_CODE : DECERR_CODE;
      exp_data = '0;
      if (hit && !we) begin
         exp_data = model[line];
      end
      access(r, hold, rsp, rise_lat, fall_lat);
      check_val("resp", 64'(exp_resp), 64'(rsp.resp));
      check_val("rdata", exp_data, rsp.rdata);
      check_val("rise latency", 3, rise_lat);
      check_val("fall latency", 1, fall_lat);
      if (hit && we) begin
         model[line] = merge_bytes(model.exists(line) ? model[line] : '0, wdata, strb);
      end
   endtask

   task automatic start_test(input string name);
      cur_test          = name;
      test_start_errors = errors;
   endtask

   task automatic finish_test();
      tests++;
      if (errors != test_start_errors) begin
         failed_tests++;
      end
      $display("%-13s done, %0d errors", cur_test, errors - test_start_errors);
   endtask

   initial begin
      int     idx;
      paddr_t addr;
      void'($urandom(32'h6565));
      rst_n_i   = 1'b0;
      req_i     = 1'b0;
      mem_req_i = '0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      failed_tests = 0;
      for (int i = 0; i < POOL_SIZE; i++) begin
         pool_line[i] = i * 512 + $urandom_range(511, 0);   // one line per 4 KB block
      end

      start_test("reset");
      for (int i = 0; i < 5; i++) begin
         @(negedge mig_clk);
         check_val("ack in reset", 0, ack_o);
      end
      @(posedge mig_clk);
      rst_n_i <= 1'b1;
      @(negedge mig_clk);
      check_val("ack after reset", 0, ack_o);
      check_val("rdata after reset", 0, mem_rsp_o.rdata);
      check_val("resp after reset", 0, 64'(mem_rsp_o.resp));
      finish_test();

      start_test("write_read");
      for (int i = 0; i < POOL_SIZE; i++) begin
         checked_access(1'b1, pool_addr(i), rand_word(), 8'hff, 0);
      end
      for (int i = 0; i < POOL_SIZE; i++) begin
         checked_access(1'b0, pool_addr(i), '0, '0, 0);
      end
      finish_test();

      start_test("byte_strobe");
      for (int i = 0; i < POOL_SIZE; i++) begin
         checked_access(1'b1, pool_addr(i), rand_word(), strb_t'($urandom), 0);
         checked_access(1'b0, pool_addr(i), '0, '0, 0);
      end
      finish_test();

      start_test("decode_error");
      for (int i = 0; i < 4; i++) begin
         checked_access(1'b0, miss_addr(i), '0, '0, 0);
         checked_access(1'b1, miss_addr(i), rand_word(), 8'hff, 0);
         checked_access(1'b0, pool_addr(i), '0, '0, 0);   // alias untouched
      end
      finish_test();

      start_test("random_mix");
      for (int n = 0; n < 200; n++) begin
         idx  = $urandom_range(POOL_SIZE - 1, 0);
         addr = ($urandom_range(3, 0) == 0) ? miss_addr(idx) : pool_addr(idx);
         checked_access(1'($urandom), addr, rand_word(), strb_t'($urandom),
                        $urandom_range(2, 0));
      end
      finish_test();

      start_test("held_request");
      for (int n = 0; n < 8; n++) begin
         idx = $urandom_range(POOL_SIZE - 1, 0);
         checked_access(1'($urandom), pool_addr(idx), rand_word(), strb_t'($urandom),
                        $urandom_range(8, 2));
      end
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, failed_tests, checks, errors, dut.u_checker.fail_count);
      if (errors == 0 && dut.u_checker.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* bender.yml */
package:
  name: boot_mem

sources:
  - src/soc_addr_pkg.sv
  - src/soc_bus_pkg.sv
  - src/mem_addr_decode.sv
  - src/bram_access.sv
  - src/resp_collect.sv
  - src/boot_mem_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/boot_mem_checker.sv
      - verification/boot_mem_tb.sv

/* files.f */
src/soc_addr_pkg.sv
src/soc_bus_pkg.sv
src/mem_addr_decode.sv
src/bram_access.sv
src/resp_collect.sv
src/boot_mem_top.sv
verification/tb_clk_gen.sv
verification/boot_mem_checker.sv
verification/boot_mem_tb.sv
